// ==== hdl/periph_settings.svh ====
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// clocks per serial bit
`define CLKS_PER_BAUD 4

// servo frame length and startup high time, in clocks
`define PWM_PERIOD 1024
`define SERVO_DUTY 384

// startup LED levels
`define LED_LEVEL_R 16
`define LED_LEVEL_G 128
`define LED_LEVEL_B 200

`endif

// ==== hdl/periph_pkg.sv ====
package periph_pkg;

	// slaves that keep only a byte use the low bits of the word
	typedef logic [31:0] wb_word_t;
	typedef logic [3:0]  wb_addr_t;

	// LED intensity, ones per 256 clocks
	typedef logic [7:0]  pdm_level_t;

	localparam int PDM_CHANNELS = 3;

	// uart register map
	typedef enum wb_addr_t {
		UART_DATA   = 4'h0,
		UART_STATUS = 4'h1
	} uart_reg_e;

	// servo duty, high time in clocks
	localparam wb_addr_t PWM_DUTY_ADDR = 4'h0;

	// first LED level, the others follow at consecutive words
	localparam wb_addr_t PDM_LEVEL_BASE = 4'h0;

endpackage

// ==== hdl/wb_if.sv ====
interface wb_if;
	import periph_pkg::*;

	logic     cyc;
	logic     stb;
	logic     we;
	wb_addr_t adr;
	wb_word_t dat_m2s;
	wb_word_t dat_s2m;
	logic     stall;
	logic     ack;

	modport master (
		output cyc,
		output stb,
		output we,
		output adr,
		output dat_m2s,
		input  dat_s2m,
		input  stall,
		input  ack
	);

	modport slave (
		input  cyc,
		input  stb,
		input  we,
		input  adr,
		input  dat_m2s,
		output dat_s2m,
		output stall,
		output ack
	);

endinterface

// ==== hdl/wb_uart.sv ====
`include "periph_settings.svh"

module wb_uart (
	input  logic clock,
	input  logic rst_n_i,
	wb_if.slave  bus,
	output logic rx_ready_o,
	input  logic uart_rx_i,
	output logic uart_tx_o
);
	import periph_pkg::*;

	localparam int BAUD_W = $clog2(`CLKS_PER_BAUD + 1);
	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`CLKS_PER_BAUD - 1);
	// first sample lands near the middle of the start bit
	localparam logic [BAUD_W-1:0] BAUD_HALF = BAUD_W'(`CLKS_PER_BAUD / 2 - 1);

	logic              accept;
	logic              wr_data;
	logic              rd_data;
	logic              tx_busy;
	logic [9:0]        tx_shift;
	logic [BAUD_W-1:0] tx_baud;
	logic [3:0]        tx_bit;
	logic              rx_meta;
	logic              rx_sync;
	logic              rx_busy;
	logic [BAUD_W-1:0] rx_baud;
	logic [3:0]        rx_bit;
	logic              rx_sample;
	logic              stop_ok;
	logic [7:0]        rx_shift;
	logic [7:0]        rx_hold;

	assign wr_data   = bus.we && bus.adr == UART_DATA;
	// a write waits until the previous frame has left
	assign bus.stall = wr_data && tx_busy;
	assign accept    = bus.cyc && bus.stb && !bus.stall;
	assign rd_data   = accept && !bus.we && bus.adr == UART_DATA;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bus.ack <= 1'b0;
		end else begin
			bus.ack <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept && !bus.we) begin
			if (bus.adr == UART_DATA)
				bus.dat_s2m <= wb_word_t'(rx_hold);
			else if (bus.adr == UART_STATUS)
				bus.dat_s2m <= wb_word_t'({rx_ready_o, tx_busy});
			else
				bus.dat_s2m <= '0;
		end
	end

	// transmitter, shifts ones in behind the frame so the line idles high
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tx_busy  <= 1'b0;
			tx_shift <= '1;
			tx_baud  <= '0;
			tx_bit   <= '0;
		end else if (accept && wr_data) begin
			tx_busy  <= 1'b1;
			tx_shift <= {1'b1, bus.dat_m2s[7:0], 1'b0};
			tx_baud  <= '0;
			tx_bit   <= '0;
		end else if (tx_busy) begin
			if (tx_baud == BAUD_LAST) begin
				tx_baud  <= '0;
				tx_shift <= {1'b1, tx_shift[9:1]};
				if (tx_bit == 4'd9)
					tx_busy <= 1'b0;
				else
					tx_bit <= tx_bit + 4'd1;
			end else begin
				tx_baud <= tx_baud + BAUD_W'(1);
			end
		end
	end

	assign uart_tx_o = tx_shift[0];

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= uart_rx_i;
			rx_sync <= rx_meta;
		end
	end

	// bit 0 is the start bit, 1 to 8 data, 9 the stop bit
	assign rx_sample = rx_busy && rx_baud == '0;
	assign stop_ok   = rx_sample && rx_bit == 4'd9 && rx_sync;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rx_busy    <= 1'b0;
			rx_baud    <= '0;
			rx_bit     <= '0;
			rx_ready_o <= 1'b0;
		end else begin
			if (!rx_busy) begin
				if (!rx_sync) begin
					rx_busy <= 1'b1;
					rx_baud <= BAUD_HALF;
					rx_bit  <= '0;
				end
			end else if (rx_baud != '0) begin
				rx_baud <= rx_baud - BAUD_W'(1);
			end else begin
				rx_baud <= BAUD_LAST;
				rx_bit  <= rx_bit + 4'd1;
				// glitch on the start bit, back to hunting
				if (rx_bit == 4'd0 && rx_sync)
					rx_busy <= 1'b0;
				else if (rx_bit == 4'd9)
					rx_busy <= 1'b0;
			end
			// a fresh byte wins over a read in the same cycle
			if (stop_ok)
				rx_ready_o <= 1'b1;
			else if (rd_data)
				rx_ready_o <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (rx_sample && rx_bit >= 4'd1 && rx_bit <= 4'd8)
			rx_shift <= {rx_sync, rx_shift[7:1]};
		if (stop_ok)
			rx_hold <= rx_shift;
	end

endmodule

// ==== hdl/wb_pwm.sv ====
`include "periph_settings.svh"

module wb_pwm (
	input  logic clock,
	input  logic rst_n_i,
	wb_if.slave  bus,
	output logic pwm_o
);
	import periph_pkg::*;

	localparam int CNT_W = $clog2(`PWM_PERIOD);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`PWM_PERIOD - 1);

	logic [CNT_W-1:0] cnt;
	wb_word_t         duty_reg;
	wb_word_t         duty_active;
	logic             accept;

	assign bus.stall = 1'b0;
	assign accept    = bus.cyc && bus.stb && !bus.stall;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bus.ack     <= 1'b0;
			duty_reg    <= '0;
			duty_active <= '0;
			cnt         <= '0;
		end else begin
			bus.ack <= accept;
			if (accept && bus.we && bus.adr == PWM_DUTY_ADDR)
				duty_reg <= bus.dat_m2s;
			// new duty only at the frame boundary
			if (cnt == CNT_LAST) begin
				cnt         <= '0;
				duty_active <= duty_reg;
			end else begin
				cnt <= cnt + CNT_W'(1);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept && !bus.we) begin
			if (bus.adr == PWM_DUTY_ADDR)
				bus.dat_s2m <= duty_reg;
			else
				bus.dat_s2m <= '0;
		end
	end

	assign pwm_o = wb_word_t'(cnt) < duty_active;

endmodule

// ==== hdl/wb_pdm.sv ====
module wb_pdm (
	input  logic clock,
	input  logic rst_n_i,
	wb_if.slave  bus,
	output logic [periph_pkg::PDM_CHANNELS-1:0] pdm_o
);
	import periph_pkg::*;

	pdm_level_t level [PDM_CHANNELS];
	pdm_level_t accum [PDM_CHANNELS];
	logic       accept;
	wb_word_t   rd_word;

	assign bus.stall = 1'b0;
	assign accept    = bus.cyc && bus.stb && !bus.stall;

	// unmapped addresses read as zero
	always_comb begin
		rd_word = '0;
		for (int i = 0; i < PDM_CHANNELS; i++) begin
			if (bus.adr == PDM_LEVEL_BASE + wb_addr_t'(i))
				rd_word = wb_word_t'(level[i]);
		end
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bus.ack <= 1'b0;
			for (int i = 0; i < PDM_CHANNELS; i++)
				level[i] <= '0;
		end else begin
			bus.ack <= accept;
			for (int i = 0; i < PDM_CHANNELS; i++) begin
				if (accept && bus.we && bus.adr == PDM_LEVEL_BASE + wb_addr_t'(i))
					level[i] <= bus.dat_m2s[7:0];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept && !bus.we)
			bus.dat_s2m <= rd_word;
	end

	// first order sigma-delta, the carry is the output bit
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pdm_o <= '0;
			for (int i = 0; i < PDM_CHANNELS; i++)
				accum[i] <= '0;
		end else begin
			for (int i = 0; i < PDM_CHANNELS; i++)
				{pdm_o[i], accum[i]} <= {1'b0, accum[i]} + {1'b0, level[i]};
		end
	end

endmodule

// ==== hdl/uart_echo_ctrl.sv ====
module uart_echo_ctrl (
	input  logic clock,
	input  logic rst_n_i,
	wb_if.master bus,
	input  logic rx_ready_i
);
	import periph_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RD_REQ,
		ST_RD_WAIT,
		ST_WR_REQ,
		ST_WR_WAIT
	} state_t;

	state_t     state;
	logic [7:0] echo_byte;

	assign bus.cyc     = state != ST_IDLE;
	assign bus.stb     = state == ST_RD_REQ || state == ST_WR_REQ;
	assign bus.we      = state == ST_WR_REQ || state == ST_WR_WAIT;
	assign bus.adr     = UART_DATA;
	assign bus.dat_m2s = wb_word_t'(echo_byte);

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (rx_ready_i)
						state <= ST_RD_REQ;
				end
				ST_RD_REQ: begin
					if (!bus.stall)
						state <= ST_RD_WAIT;
				end
				ST_RD_WAIT: begin
					if (bus.ack)
						state <= ST_WR_REQ;
				end
				// held here while the transmitter is still sending
				ST_WR_REQ: begin
					if (!bus.stall)
						state <= ST_WR_WAIT;
				end
				ST_WR_WAIT: begin
					if (bus.ack)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == ST_RD_WAIT && bus.ack)
			echo_byte <= bus.dat_s2m[7:0];
	end

endmodule

// ==== hdl/startup_writer.sv ====
`include "periph_settings.svh"

module startup_writer (
	input  logic clock,
	input  logic rst_n_i,
	wb_if.master pwm_bus,
	wb_if.master pdm_bus,
	output logic done_o
);
	import periph_pkg::*;

	localparam int IDX_W = $clog2(PDM_CHANNELS);

	typedef enum logic [2:0] {
		ST_START,
		ST_PWM_REQ,
		ST_PWM_WAIT,
		ST_PDM_REQ,
		ST_PDM_WAIT,
		ST_DONE
	} state_t;

	state_t           state;
	logic [IDX_W-1:0] idx;
	pdm_level_t       level;

	// red, green, blue in address order
	always_comb begin
		case (idx)
			IDX_W'(0): level = pdm_level_t'(`LED_LEVEL_R);
			IDX_W'(1): level = pdm_level_t'(`LED_LEVEL_G);
			default:   level = pdm_level_t'(`LED_LEVEL_B);
		endcase
	end

	assign pwm_bus.cyc     = state == ST_PWM_REQ || state == ST_PWM_WAIT;
	assign pwm_bus.stb     = state == ST_PWM_REQ;
	assign pwm_bus.we      = 1'b1;
	assign pwm_bus.adr     = PWM_DUTY_ADDR;
	assign pwm_bus.dat_m2s = wb_word_t'(`SERVO_DUTY);

	assign pdm_bus.cyc     = state == ST_PDM_REQ || state == ST_PDM_WAIT;
	assign pdm_bus.stb     = state == ST_PDM_REQ;
	assign pdm_bus.we      = 1'b1;
	assign pdm_bus.adr     = PDM_LEVEL_BASE + wb_addr_t'(idx);
	assign pdm_bus.dat_m2s = wb_word_t'(level);

	assign done_o = state == ST_DONE;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= ST_START;
			idx   <= '0;
		end else begin
			case (state)
				ST_START:    state <= ST_PWM_REQ;
				ST_PWM_REQ:  if (!pwm_bus.stall) state <= ST_PWM_WAIT;
				ST_PWM_WAIT: if (pwm_bus.ack) state <= ST_PDM_REQ;
				ST_PDM_REQ:  if (!pdm_bus.stall) state <= ST_PDM_WAIT;
				ST_PDM_WAIT: begin
					if (pdm_bus.ack) begin
						if (idx == IDX_W'(PDM_CHANNELS - 1)) begin
							state <= ST_DONE;
						end else begin
							idx   <= idx + IDX_W'(1);
							state <= ST_PDM_REQ;
						end
					end
				end
				// parked for good
				default:     state <= ST_DONE;
			endcase
		end
	end

endmodule

// ==== hdl/periph_top.sv ====
module periph_top (
	input  logic clock,
	input  logic rst_n_i,
	input  logic uart_rx_i,
	output logic uart_tx_o,
	output logic pwm_servo_o,
	output logic led_r_o,
	output logic led_g_o,
	output logic led_b_o,
	output logic init_done_o
);
	import periph_pkg::*;

	logic                    rx_ready;
	logic [PDM_CHANNELS-1:0] pdm;

	wb_if uart_bus ();
	wb_if pwm_bus ();
	wb_if pdm_bus ();

	// serial echo path
	uart_echo_ctrl u_echo (
		.clock      (clock),
		.rst_n_i    (rst_n_i),
		.bus        (uart_bus.master),
		.rx_ready_i (rx_ready)
	);

	wb_uart u_uart (
		.clock      (clock),
		.rst_n_i    (rst_n_i),
		.bus        (uart_bus.slave),
		.rx_ready_o (rx_ready),
		.uart_rx_i  (uart_rx_i),
		.uart_tx_o  (uart_tx_o)
	);

	// one-shot configuration of servo and LEDs
	startup_writer u_startup (
		.clock   (clock),
		.rst_n_i (rst_n_i),
		.pwm_bus (pwm_bus.master),
		.pdm_bus (pdm_bus.master),
		.done_o  (init_done_o)
	);

	wb_pwm u_pwm (
		.clock   (clock),
		.rst_n_i (rst_n_i),
		.bus     (pwm_bus.slave),
		.pwm_o   (pwm_servo_o)
	);

	wb_pdm u_pdm (
		.clock   (clock),
		.rst_n_i (rst_n_i),
		.bus     (pdm_bus.slave),
		.pdm_o   (pdm)
	);

	assign led_r_o = pdm[0];
	assign led_g_o = pdm[1];
	assign led_b_o = pdm[2];

endmodule

// ==== sim/periph_tb.sv ====
`include "periph_settings.svh"

module periph_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// six bytes in and six echoed out, three servo frames, two LED windows with gaps
	localparam int INIT_CLKS     = 2 + 50 + 1;
	localparam int ECHO_CLKS     = 12 * 10 * `CLKS_PER_BAUD;
	localparam int SERVO_CLKS    = 3 * `PWM_PERIOD;
	localparam int LED_CLKS      = 2 * (256 + 64) + 8;
	localparam int WATCHDOG_CLKS = (INIT_CLKS + ECHO_CLKS + SERVO_CLKS + LED_CLKS) * 6 / 5;

	logic clock;
	logic rst_n_i;
	logic uart_rx_i;
	logic uart_tx_o;
	logic pwm_servo_o;
	logic led_r_o;
	logic led_g_o;
	logic led_b_o;
	logic init_done_o;

	logic [7:0] tx_bytes [$];
	int         errors;
	int         tests_run;
	int         tests_failed;

	periph_top dut (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.uart_rx_i   (uart_rx_i),
		.uart_tx_o   (uart_tx_o),
		.pwm_servo_o (pwm_servo_o),
		.led_r_o     (led_r_o),
		.led_g_o     (led_g_o),
		.led_b_o     (led_b_o),
		.init_done_o (init_done_o)
	);

	always #10 clock = ~clock;

	// once done, the startup sequencer stays parked
	init_done_sticky: assert property (@(posedge clock) disable iff (!rst_n_i)
		init_done_o |=> init_done_o)
	else begin
		$display("[FAIL] %0t: init_done_o fell after rising", $time);
		errors++;
	end

	// a stalled echo write keeps its request, address and byte steady
	echo_write_held: assert property (@(posedge clock) disable iff (!rst_n_i)
		dut.uart_bus.stb && dut.uart_bus.stall |=>
		dut.uart_bus.stb && $stable(dut.uart_bus.we) && $stable(dut.uart_bus.adr) &&
		$stable(dut.uart_bus.dat_m2s))
	else begin
		$display("[FAIL] %0t: echo write dropped or changed under stall", $time);
		errors++;
	end

	task automatic expect_value(input string what, input int got, input int want);
		assert (got == want)
		else begin
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - start_errors);
		end
	endtask

	// one 8N1 frame, lsb first, each bit held for a full baud period
	task automatic send_byte(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clock);
			#2;
			uart_rx_i = frame[i];
			repeat (`CLKS_PER_BAUD - 1) @(posedge clock);
		end
	endtask

	// decodes uart_tx_o, every bit must hold for exactly one baud period
	initial begin : serial_monitor
		logic [7:0] data;
		logic       bit_level;
		logic       frame_ok;
		data = '0;
		forever begin
			@(negedge clock);
			if (rst_n_i && uart_tx_o == 1'b0) begin
				frame_ok = 1'b1;
				for (int i = 0; i < 10; i++) begin
					bit_level = uart_tx_o;
					for (int k = 1; k < `CLKS_PER_BAUD; k++) begin
						@(negedge clock);
						if (uart_tx_o !== bit_level)
							frame_ok = 1'b0;
					end
					if (i >= 1 && i <= 8)
						data[i-1] = bit_level;
					if (i == 9 && bit_level !== 1'b1)
						frame_ok = 1'b0;
					if (i < 9)
						@(negedge clock);
				end
				assert (frame_ok)
				else begin
					$display("[FAIL] %0t: malformed 8N1 frame on uart_tx_o", $time);
					errors++;
				end
				tx_bytes.push_back(data);
			end
		end
	end

	task automatic verify_reset_state();
		int start_errors;
		int waited;
		start_errors = errors;
		@(negedge clock);
		expect_value("uart_tx_o after reset", int'(uart_tx_o), 1);
		expect_value("pwm_servo_o after reset", int'(pwm_servo_o), 0);
		expect_value("led_r_o after reset", int'(led_r_o), 0);
		expect_value("led_g_o after reset", int'(led_g_o), 0);
		expect_value("led_b_o after reset", int'(led_b_o), 0);
		expect_value("init_done_o after reset", int'(init_done_o), 0);
		waited = 0;
		while (!init_done_o && waited < 50) begin
			@(negedge clock);
			waited++;
		end
		assert (init_done_o)
		else begin
			$display("[FAIL] %0t: init_done_o still low after 50 clocks", $time);
			errors++;
		end
		report_test("reset_state", start_errors);
	endtask

	task automatic echo_random_bytes(input string name, input int count);
		logic [7:0] sent [$];
		int         start_errors;
		int         waited;
		int         limit;
		start_errors = errors;
		limit = (count + 2) * 10 * `CLKS_PER_BAUD + 20;
		tx_bytes.delete();
		for (int i = 0; i < count; i++)
			sent.push_back(8'($urandom));
		// no idle gap between frames
		foreach (sent[i])
			send_byte(sent[i]);
		waited = 0;
		while (tx_bytes.size() < count && waited < limit) begin
			@(negedge clock);
			waited++;
		end
		assert (tx_bytes.size() >= count)
		else begin
			$display("echo stopped early: only %0d of %0d bytes came back on uart_tx_o",
				tx_bytes.size(), count);
			errors++;
		end
		if (tx_bytes.size() >= count) begin
			foreach (sent[i]) begin
				assert (tx_bytes[i] == sent[i])
				else begin
					$display("[FAIL] %0t: echo byte %0d is %02h, expected %02h",
						$time, i, tx_bytes[i], sent[i]);
					errors++;
				end
			end
		end
		report_test(name, start_errors);
	endtask

	task automatic measure_servo_frames();
		int start_errors;
		int high_cnt;
		int period_cnt;
		start_errors = errors;
		// align to a rising edge so only whole frames are measured
		@(negedge clock);
		while (pwm_servo_o)
			@(negedge clock);
		while (!pwm_servo_o)
			@(negedge clock);
		for (int f = 0; f < 2; f++) begin
			high_cnt = 0;
			period_cnt = 0;
			while (pwm_servo_o) begin
				high_cnt++;
				period_cnt++;
				@(negedge clock);
			end
			while (!pwm_servo_o) begin
				period_cnt++;
				@(negedge clock);
			end
			expect_value("servo high time", high_cnt, `SERVO_DUTY);
			expect_value("servo period", period_cnt, `PWM_PERIOD);
		end
		report_test("servo_duty", start_errors);
	endtask

	task automatic count_led_ones();
		int start_errors;
		int ones_r;
		int ones_g;
		int ones_b;
		start_errors = errors;
		repeat (8) @(negedge clock);
		for (int w = 0; w < 2; w++) begin
			ones_r = 0;
			ones_g = 0;
			ones_b = 0;
			repeat (256) begin
				@(negedge clock);
				ones_r += int'(led_r_o);
				ones_g += int'(led_g_o);
				ones_b += int'(led_b_o);
			end
			expect_value("red ones per 256 clocks", ones_r, `LED_LEVEL_R);
			expect_value("green ones per 256 clocks", ones_g, `LED_LEVEL_G);
			expect_value("blue ones per 256 clocks", ones_b, `LED_LEVEL_B);
			repeat (64) @(negedge clock);
		end
		report_test("led_density", start_errors);
	endtask

	initial begin : watchdog
		repeat (WATCHDOG_CLKS) @(posedge clock);
		$display("timeout: the run did not finish within %0d clocks", WATCHDOG_CLKS);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin : main
		clock        = 1'b0;
		rst_n_i      = 1'b0;
		uart_rx_i    = 1'b1;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		void'($urandom(32'hbed3441e));
		repeat (2) @(posedge clock);
		#2;
		rst_n_i = 1'b1;

		verify_reset_state();
		echo_random_bytes("single_echo", 1);
		echo_random_bytes("back_to_back_echo", 5);
		measure_servo_frames();
		count_led_ones();

		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== periph_demo.f ====
+incdir+hdl
hdl/periph_pkg.sv
hdl/wb_if.sv
hdl/wb_uart.sv
hdl/wb_pwm.sv
hdl/wb_pdm.sv
hdl/uart_echo_ctrl.sv
hdl/startup_writer.sv
hdl/periph_top.sv
sim/periph_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the periph_demo testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module periph_tb \
	-f periph_demo.f \
	-o periph_sim

./obj_dir/periph_sim | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
